// File: logic/morraPkg.sv
package morraPkg;

  localparam int MoveWidth = 2;

  // move codes, zero means the player did not play
  localparam logic [MoveWidth-1:0] MoveNone     = 2'd0;
  localparam logic [MoveWidth-1:0] MoveRock     = 2'd1;
  localparam logic [MoveWidth-1:0] MovePaper    = 2'd2;
  localparam logic [MoveWidth-1:0] MoveScissors = 2'd3;

  // shared by round and match result, none = in progress for the match
  localparam logic [1:0] ResultNone = 2'd0;
  localparam logic [1:0] ResultP1   = 2'd1;
  localparam logic [1:0] ResultP2   = 2'd2;
  localparam logic [1:0] ResultDraw = 2'd3;

  // 4 + 15 rounds at most with the default minimum
  localparam int CountWidth = 5;
  localparam int LeadWidth  = 6;

  typedef struct packed {
    logic [MoveWidth-1:0] p1Move; // upper bits
    logic [MoveWidth-1:0] p2Move;
  } movePair_s;

  // the same word is a move pair, or the extra round count on start
  typedef union packed {
    movePair_s moves;
    logic [2*MoveWidth-1:0] extraRounds;
  } playWord_u;

endpackage

// File: logic/moveJudge.sv
`timescale 1ns/1ps

module moveJudge import morraPkg::*; (
  input  logic       clk,
  input  logic       arstN,
  input  logic       start,
  input  logic       matchOver,
  input  playWord_u  play,
  output logic [1:0] outcome,
  output logic [1:0] roundResult
);

  movePair_s remembered; // last winning move of each player
  movePair_s cur;
  logic      validRound;

  function automatic logic beats(input logic [MoveWidth-1:0] a,
                                 input logic [MoveWidth-1:0] b);
    return (a == MoveRock     && b == MoveScissors) ||
           (a == MovePaper    && b == MoveRock)     ||
           (a == MoveScissors && b == MovePaper);
  endfunction

  assign cur = play.moves;

  // an empty memory slot never matches a real move
  assign validRound = (cur.p1Move != MoveNone) && (cur.p2Move != MoveNone) &&
                      (cur.p1Move != remembered.p1Move) &&
                      (cur.p2Move != remembered.p2Move);

  always_comb begin
    if (start || matchOver || !validRound) begin
      outcome = ResultNone;
    end else if (cur.p1Move == cur.p2Move) begin
      outcome = ResultDraw;
    end else if (beats(cur.p1Move, cur.p2Move)) begin
      outcome = ResultP1;
    end else begin
      outcome = ResultP2;
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      roundResult <= ResultNone;
      remembered  <= '0;
    end else if (start) begin
      roundResult <= ResultNone;
      remembered  <= '0;
    end else begin
      roundResult <= outcome;
      case (outcome)
        ResultP1: begin
          remembered.p1Move <= cur.p1Move; // loser forgets
          remembered.p2Move <= MoveNone;
        end
        ResultP2: begin
          remembered.p1Move <= MoveNone;
          remembered.p2Move <= cur.p2Move;
        end
        ResultDraw: begin
          remembered <= '0;
        end
        default: begin
          remembered <= remembered; // invalid round keeps memory
        end
      endcase
    end
  end

  // only the last winner can hold a remembered move
  oneMemory: assert property (@(posedge clk) disable iff (!arstN)
    !(remembered.p1Move != MoveNone && remembered.p2Move != MoveNone))
    else $error("both players hold a remembered move");

endmodule

// File: logic/roundTracker.sv
`timescale 1ns/1ps

module roundTracker import morraPkg::*; #(
  parameter int MinRounds = 4
) (
  input  logic       clk,
  input  logic       arstN,
  input  logic       start,
  input  playWord_u  play,
  input  logic [1:0] outcome,
  output logic       minReached,
  output logic       lastRound
);

  logic [CountWidth-1:0] roundCount;
  logic [CountWidth-1:0] maxRounds;
  logic [CountWidth-1:0] countNext;

  assign countNext = roundCount + 1'b1; // count if this round is valid

  assign minReached = countNext >= CountWidth'(MinRounds);
  assign lastRound  = countNext == maxRounds;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      roundCount <= '0;
      maxRounds  <= CountWidth'(MinRounds);
    end else if (start) begin
      roundCount <= '0;
      maxRounds  <= CountWidth'(MinRounds) + CountWidth'(play.extraRounds);
    end else if (outcome != ResultNone) begin
      roundCount <= countNext;
    end
  end

  // the scorer has to close the match before the count runs past the limit
  countBound: assert property (@(posedge clk) disable iff (!arstN)
    roundCount <= maxRounds)
    else $error("round count %0d beyond maximum %0d", roundCount, maxRounds);

endmodule

// File: logic/matchScorer.sv
`timescale 1ns/1ps

module matchScorer import morraPkg::*; #(
  parameter int WinMargin = 2
) (
  input  logic       clk,
  input  logic       arstN,
  input  logic       start,
  input  logic [1:0] outcome,
  input  logic       minReached,
  input  logic       lastRound,
  output logic       matchOver,
  output logic [1:0] matchResult
);

  logic signed [LeadWidth-1:0] lead; // positive means p1 ahead
  logic signed [LeadWidth-1:0] leadNext;
  logic signed [LeadWidth-1:0] leadMag;
  logic                        marginMet;
  logic [1:0]                  leader;
  logic                        roundPlayed;

  assign roundPlayed = outcome != ResultNone;

  always_comb begin
    case (outcome)
      ResultP1: leadNext = lead + LeadWidth'(1);
      ResultP2: leadNext = lead - LeadWidth'(1);
      default:  leadNext = lead;
    endcase
  end

  assign leadMag   = (leadNext < 0) ? -leadNext : leadNext;
  assign marginMet = leadMag >= LeadWidth'(WinMargin);
  assign leader    = (leadNext > 0) ? ResultP1 : ResultP2;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      lead        <= '0;
      matchOver   <= 1'b0;
      matchResult <= ResultNone;
    end else if (start) begin
      lead        <= '0;
      matchOver   <= 1'b0;
      matchResult <= ResultNone;
    end else if (roundPlayed) begin
      lead <= leadNext;
      if (minReached && marginMet) begin
        matchOver   <= 1'b1; // early win
        matchResult <= leader;
      end else if (lastRound) begin
        matchOver   <= 1'b1;
        matchResult <= marginMet ? leader : ResultDraw;
      end
    end
  end

  // relies on the judge muting rounds once the match is closed
  resultHeld: assert property (@(posedge clk) disable iff (!arstN)
    matchOver && !start |=> $stable(matchResult))
    else $error("match result changed after the end of the match");

endmodule

// File: logic/morraReferee.sv
`timescale 1ns/1ps

module morraReferee import morraPkg::*; #(
  parameter int MinRounds = 4,
  parameter int WinMargin = 2
) (
  input  logic       clk,
  input  logic       arstN,
  input  logic       start,
  input  playWord_u  play,
  output logic [1:0] roundResult,
  output logic [1:0] matchResult
);

  logic [1:0] outcome; // combinational result of the word on the bus
  logic       minReached;
  logic       lastRound;
  logic       matchOver;

  moveJudge judge (
    .clk         (clk),
    .arstN       (arstN),
    .start       (start),
    .matchOver   (matchOver),
    .play        (play),
    .outcome     (outcome),
    .roundResult (roundResult)
  );

  roundTracker #(
    .MinRounds (MinRounds)
  ) tracker (
    .clk        (clk),
    .arstN      (arstN),
    .start      (start),
    .play       (play),
    .outcome    (outcome),
    .minReached (minReached),
    .lastRound  (lastRound)
  );

  matchScorer #(
    .WinMargin (WinMargin)
  ) scorer (
    .clk         (clk),
    .arstN       (arstN),
    .start       (start),
    .outcome     (outcome),
    .minReached  (minReached),
    .lastRound   (lastRound),
    .matchOver   (matchOver),
    .matchResult (matchResult)
  );

endmodule

// File: verification/tbClock.sv
`timescale 1ns/1ps

module tbClock #(
  parameter int Period      = 20,
  parameter int ResetCycles = 2
) (
  output logic clk,
  output logic arstN
);

  initial begin
    clk = 1'b0;
    forever #(Period / 2) clk = ~clk;
  end

  initial begin
    arstN = 1'b0;
    repeat (ResetCycles) @(posedge clk);
    arstN <= 1'b1; // released on an edge, seen by the DUT one edge later
  end

endmodule

// File: verification/tbChecker.sv
`timescale 1ns/1ps

module tbChecker import morraPkg::*; (
  input  logic       clk,
  input  logic       arstN,
  input  logic       checkEn,
  input  int         vecLine,
  input  logic [1:0] expRound,
  input  logic [1:0] expMatch,
  input  logic [1:0] roundResult,
  input  logic [1:0] matchResult,
  output int         errorCount
);

  logic       checkDue; // the DUT sampled a vector on the last edge
  logic [1:0] dueRound;
  logic [1:0] dueMatch;
  int         dueLine;
  int         mismatches = 0;

  assign errorCount = mismatches;

  // expected values lag the driven word by one edge, like the DUT outputs
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      checkDue <= 1'b0;
      dueRound <= ResultNone;
      dueMatch <= ResultNone;
      dueLine  <= 0;
    end else begin
      checkDue <= checkEn;
      dueRound <= expRound;
      dueMatch <= expMatch;
      dueLine  <= vecLine;
    end
  end

  always @(negedge clk) begin
    if (!arstN) begin
      if (roundResult !== ResultNone || matchResult !== ResultNone) begin
        mismatches++;
        $display("mismatch at %0t ns: outputs not cleared in reset, round %0d match %0d",
                 $time, roundResult, matchResult);
      end
    end else if (checkDue) begin
      if (roundResult !== dueRound) begin
        mismatches++;
        $display("mismatch at %0t ns: vector line %0d roundResult is %0d, expected %0d",
                 $time, dueLine, roundResult, dueRound);
      end
      if (matchResult !== dueMatch) begin
        mismatches++;
        $display("mismatch at %0t ns: vector line %0d matchResult is %0d, expected %0d",
                 $time, dueLine, matchResult, dueMatch);
      end
    end
  end

endmodule

// File: verification/tbTop.sv
`timescale 1ns/1ps

module tbTop import morraPkg::*; ();

  localparam int    ClockPeriod = 20;
  localparam string VecFile     = "verification/morraVectors.txt";

  typedef struct packed {
    logic       start;
    logic [1:0] p1Move; // doubles as the upper extraRounds bits
    logic [1:0] p2Move;
    logic [1:0] expRound;
    logic [1:0] expMatch;
  } vector_s;

  logic       clk;
  logic       arstN;
  logic       start;
  playWord_u  play;
  logic [1:0] roundResult;
  logic [1:0] matchResult;
  logic       checkEn;
  logic [1:0] expRound;
  logic [1:0] expMatch;
  int         vecLine;
  int         errorCount;
  int         otherErrors = 0;
  bit         loaded = 1'b0;
  vector_s    vectors[$];
  int         lineNums[$];

  tbClock #(.Period(ClockPeriod), .ResetCycles(2)) clockGen (
    .clk   (clk),
    .arstN (arstN)
  );

  morraReferee #(
    .MinRounds (4),
    .WinMargin (2)
  ) DUT (
    .clk         (clk),
    .arstN       (arstN),
    .start       (start),
    .play        (play),
    .roundResult (roundResult),
    .matchResult (matchResult)
  );

  tbChecker resultCheck (
    .clk         (clk),
    .arstN       (arstN),
    .checkEn     (checkEn),
    .vecLine     (vecLine),
    .expRound    (expRound),
    .expMatch    (expMatch),
    .roundResult (roundResult),
    .matchResult (matchResult),
    .errorCount  (errorCount)
  );

  // lines that do not hold five numbers are comments
  task automatic loadVectors(output bit ok);
    int      fd;
    int      code;
    int      lineNo;
    int      s;
    int      a;
    int      b;
    int      r;
    int      m;
    string   line;
    vector_s v;
    ok = 1'b0;
    lineNo = 0;
    fd = $fopen(VecFile, "r");
    if (fd == 0) return;
    while (!$feof(fd)) begin
      code = $fgets(line, fd);
      lineNo++;
      if (code > 0 && $sscanf(line, "%d %d %d %d %d", s, a, b, r, m) == 5) begin
        v.start    = s[0];
        v.p1Move   = a[1:0];
        v.p2Move   = b[1:0];
        v.expRound = r[1:0];
        v.expMatch = m[1:0];
        vectors.push_back(v);
        lineNums.push_back(lineNo);
      end
    end
    $fclose(fd);
    ok = 1'b1;
  endtask

  task automatic applyVector(input vector_s v, input int fileLine);
    @(posedge clk);
    start              <= v.start;
    play.moves.p1Move  <= v.p1Move;
    play.moves.p2Move  <= v.p2Move;
    expRound           <= v.expRound;
    expMatch           <= v.expMatch;
    vecLine            <= fileLine;
    checkEn            <= 1'b1;
  endtask

  task automatic finishRun();
    $display("closing count: %0d mismatches, %0d other errors", errorCount, otherErrors);
    if (errorCount + otherErrors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  endtask

  initial begin : stimulus
    bit ok;
    start    = 1'b0;
    play     = '0;
    checkEn  = 1'b0;
    expRound = ResultNone;
    expMatch = ResultNone;
    vecLine  = 0;
    loadVectors(ok);
    if (!ok) begin
      $display("could not open the vector file %s", VecFile);
      otherErrors++;
      finishRun();
    end else if (vectors.size() == 0) begin
      $display("the vector file %s holds no vectors", VecFile);
      otherErrors++;
      finishRun();
    end else begin
      loaded = 1'b1;
      wait (arstN === 1'b1);
      foreach (vectors[i]) applyVector(vectors[i], lineNums[i]);
      @(posedge clk);
      start   <= 1'b0;
      play    <= '0;
      checkEn <= 1'b0;
      repeat (2) @(posedge clk); // let the last result be compared
      finishRun();
    end
  end

  initial begin : watchdog
    wait (loaded);
    #((vectors.size() + 10) * ClockPeriod);
    $display("timeout: the run did not end within %0d clock cycles", vectors.size() + 10);
    otherErrors++;
    finishRun();
  end

endmodule

// File: verification/morraVectors.txt
# columns: start p1Move p2Move expRound expMatch, one row per clock cycle
# on start rows p1Move,p2Move form extraRounds; results 0 none 1 p1 2 p2 3 draw
# idle word straight after reset
0 0 0 0 0
# beat rule, draws first, then each win from a fresh start
1 3 3 0 0
0 1 1 3 0
0 2 2 3 0
0 3 3 3 0
1 3 3 0 0
0 1 2 2 0
1 3 3 0 0
0 1 3 1 0
1 3 3 0 0
0 2 1 1 0
1 3 3 0 0
0 2 3 2 0
1 3 3 0 0
0 3 1 2 0
1 3 3 0 0
0 3 2 1 0
# empty moves and repeated remembered moves
1 3 3 0 0
0 0 1 0 0
0 2 0 0 0
0 0 0 0 0
0 1 3 1 0
0 1 2 0 0
0 1 3 0 0
0 2 1 1 0
0 3 3 3 0
0 1 2 2 0
0 3 2 0 0
0 3 1 2 0
# memory cleared by a draw
1 3 3 0 0
0 2 1 1 0
0 2 3 0 0
0 3 3 3 0
0 2 3 2 0
# early win at round 4, extraRounds 6
1 1 2 0 0
0 1 3 1 0
0 3 3 3 0
0 2 1 1 0
0 1 1 3 1
0 1 3 0 1
0 2 1 0 1
0 0 0 0 1
# maximum of 4 rounds with lead 1 ends in a draw
1 0 0 0 0
0 1 3 1 0
0 2 2 3 0
0 3 3 3 0
0 1 1 3 3
0 2 1 0 3
# maximum of 6 rounds, p1 reaches lead 2 on the last one
1 0 2 0 0
0 1 3 1 0
0 3 1 2 0
0 2 3 2 0
0 2 1 1 0
0 3 2 1 0
0 1 3 1 1
0 2 1 0 1
# start in the middle of a match
1 0 0 0 0
0 1 3 1 0
0 2 1 1 0
1 0 0 0 0
0 2 3 2 0
0 3 1 2 0
0 3 3 3 0
0 1 1 3 2
0 1 2 0 2

// File: list.f
logic/morraPkg.sv
logic/moveJudge.sv
logic/roundTracker.sv
logic/matchScorer.sv
logic/morraReferee.sv
verification/tbClock.sv
verification/tbChecker.sv
verification/tbTop.sv

// File: Makefile
BUILD = build

.PHONY: compile run clean

compile:
	verilator --binary --assert --top-module tbTop -Mdir $(BUILD) -f list.f

# a simulator that stops on its own counts as a failed run
run: compile
	./$(BUILD)/VtbTop > sim.log 2>&1 || echo "SOME TESTS FAILED" >> sim.log
	cat sim.log
	@if grep -q "SOME TESTS FAILED" sim.log; then \
		echo "simulation failed, see sim.log"; \
		exit 1; \
	else \
		echo "simulation passed"; \
	fi

clean:
	rm -rf $(BUILD) sim.log
